//--- compile.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/decoder.sv
src/reg_file.sv
src/alu.sv
src/hazard_unit.sv
src/data_mem.sv
src/pipe_core.sv
tests/tb_pipe_core.sv

//--- Makefile
TOP = tb_pipe_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module pipe_core

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

//--- tests/tb_pipe_core.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module tb_pipe_core
	import isa_pkg::*;
;

	localparam int N_INSTR     = 22 + 60; // Directed plus random
	localparam int CYCLE_LIMIT = 6 * N_INSTR + 200;

	typedef struct packed {
		logic [`CORE_REG_AW-1:0] reg_num;
		logic [`CORE_DATA_W-1:0] data;
	} wb_exp_t;

	logic                    clk = 1'b0;
	logic                    reset;
	logic                    instr_valid;
	logic [31:0]             instr;
	logic                    instr_ready;
	logic                    wb_valid;
	logic [`CORE_REG_AW-1:0] wb_reg;
	logic [`CORE_DATA_W-1:0] wb_data;

	logic [`CORE_DATA_W-1:0] model_regs [0:31];
	logic [`CORE_DATA_W-1:0] model_mem [0:`CORE_DMEM_WORDS-1];
	wb_exp_t                 exp_q [$];
	integer                  seed;
	int                      errors = 0;
	int                      tests = 0;
	int                      failed = 0;
	int                      cycles = 0;

	pipe_core u_dut (
		.clk(clk), .reset(reset),
		.instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	// --------------------
	// Instruction words
	// --------------------
	function automatic logic [31:0] r_type(input funct_e f, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, f};
	endfunction

	function automatic logic [31:0] i_type(input opcode_e op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// --------------------
	// Reference model
	// --------------------
	task automatic model_exec(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] val;
		logic [31:0] addr;
		logic [4:0]  dest;
		logic        writes;
		a      = model_regs[w[25:21]];
		b      = model_regs[w[20:16]];
		sext   = {{16{w[15]}}, w[15:0]};
		addr   = a + sext;
		val    = '0;
		dest   = w[20:16]; // rt for I-type
		writes = 1'b1;
		case (w[31:26])
			OP_RTYPE: begin
				dest = w[15:11];
				case (w[5:0])
					F_ADD:   val = a + b;
					F_SUB:   val = a - b;
					F_AND:   val = a & b;
					F_OR:    val = a | b;
					F_SLT:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					F_SLTU:  val = (a < b) ? 32'd1 : 32'd0;
					default: writes = 1'b0;
				endcase
			end
			OP_ADDI: val = a + sext;
			OP_SLTI: val = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
			OP_ORI:  val = a | {16'd0, w[15:0]};
			OP_LW:   val = model_mem[addr[7:2]];
			OP_SW: begin
				model_mem[addr[7:2]] = b;
				writes = 1'b0;
			end
			default: writes = 1'b0;
		endcase
		if (writes && dest != 5'd0) begin
			model_regs[dest] = val;
			exp_q.push_back('{reg_num: dest, data: val});
		end
	endtask

	// Offers one word and returns how many cycles instr_ready held it off
	task automatic issue(input logic [31:0] word, output int waited);
		waited      = 0;
		instr_valid = 1'b1;
		instr       = word;
		@(negedge clk);
		while (!instr_ready) begin
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		instr       = '0;
		model_exec(word);
	endtask

	task automatic send(input logic [31:0] word);
		int waited;
		issue(word, waited);
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk); // Room for stray pulses
		#1;
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: FAILED with %0d errors", name, errors - errors_before);
		end
	endtask

	always @(negedge clk) begin : monitor
		wb_exp_t exp;
		if (!reset && wb_valid) begin
			assert (exp_q.size() != 0) else begin
				$display("unexpected writeback to r%0d while no write was pending", wb_reg);
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp = exp_q.pop_front();
				assert (wb_reg == exp.reg_num) else begin
					$display("mismatch wb_reg: got %h, expected %h", wb_reg, exp.reg_num);
					errors++;
				end
				assert (wb_data == exp.data) else begin
					$display("mismatch wb_data: got %h, expected %h", wb_data, exp.data);
					errors++;
				end
			end
		end
	end

	// --------------------
	// Directed tests
	// --------------------
	task automatic test_reset_state();
		int e0;
		e0 = errors;
		@(negedge clk);
		assert (instr_ready === 1'b1) else begin
			$display("mismatch instr_ready: got %h, expected 1", instr_ready);
			errors++;
		end
		assert (wb_valid === 1'b0) else begin
			$display("mismatch wb_valid: got %h, expected 0", wb_valid);
			errors++;
		end
		@(posedge clk);
		#1;
		send(r_type(F_ADD, 5'd1, 5'd0, 5'd0));
		drain();
		report_test("reset_state", e0);
	endtask

	task automatic test_forward_chain();
		int e0;
		e0 = errors;
		send(i_type(OP_ADDI, 5'd1, 5'd0, 16'h0123));
		send(r_type(F_ADD, 5'd2, 5'd1, 5'd1));
		send(r_type(F_SUB, 5'd3, 5'd2, 5'd1));   // Memory and writeback forwards
		send(r_type(F_AND, 5'd4, 5'd3, 5'd2));
		send(r_type(F_OR, 5'd5, 5'd4, 5'd3));
		send(r_type(F_SLT, 5'd6, 5'd4, 5'd5));
		send(r_type(F_SLTU, 5'd7, 5'd6, 5'd5));
		drain();
		report_test("forward_chain", e0);
	endtask

	task automatic test_immediates();
		int e0;
		e0 = errors;
		send(i_type(OP_ADDI, 5'd1, 5'd0, 16'hfffb)); // -5
		send(i_type(OP_SLTI, 5'd2, 5'd1, 16'hfffd));
		send(i_type(OP_SLTI, 5'd3, 5'd1, 16'hfffa));
		send(i_type(OP_ORI, 5'd4, 5'd0, 16'h8001));  // No sign fill
		send(i_type(OP_ADDI, 5'd5, 5'd4, 16'h8000));
		drain();
		report_test("immediates", e0);
	endtask

	task automatic test_load_use();
		int e0;
		int waited;
		e0 = errors;
		send(i_type(OP_ADDI, 5'd1, 5'd0, 16'h55aa));
		send(i_type(OP_SW, 5'd1, 5'd0, 16'h0008));
		send(i_type(OP_LW, 5'd2, 5'd0, 16'h0008));
		issue(r_type(F_ADD, 5'd3, 5'd2, 5'd1), waited);
		assert (waited == 0) else begin
			$display("mismatch add wait cycles: got %h, expected 0", waited);
			errors++;
		end
		// The add sits in decode while the load finishes
		issue(r_type(F_OR, 5'd4, 5'd1, 5'd0), waited);
		assert (waited == 1) else begin
			$display("mismatch instr_ready low cycles: got %h, expected 1", waited);
			errors++;
		end
		drain();
		report_test("load_use", e0);
	endtask

	task automatic test_r0_writes();
		int e0;
		e0 = errors;
		send(i_type(OP_ADDI, 5'd0, 5'd0, 16'h0007));
		send(r_type(F_ADD, 5'd0, 5'd1, 5'd1));
		send(r_type(F_ADD, 5'd6, 5'd0, 5'd0));
		send(i_type(OP_ORI, 5'd7, 5'd0, 16'h0003));
		drain();
		report_test("r0_writes", e0);
	endtask

	task automatic test_random();
		int          e0;
		int          kind;
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] moff;
		e0 = errors;
		for (int i = 0; i < 60; i++) begin
			kind = $unsigned($random(seed)) % 11;
			r    = $random(seed);
			rd   = {2'b00, r[2:0]};
			rs   = {2'b00, r[5:3]};
			rt   = {2'b00, r[8:6]};
			moff = {10'd0, r[12:9], 2'b00}; // Words 0 to 15
			case (kind)
				0:       send(r_type(F_ADD, rd, rs, rt));
				1:       send(r_type(F_SUB, rd, rs, rt));
				2:       send(r_type(F_AND, rd, rs, rt));
				3:       send(r_type(F_OR, rd, rs, rt));
				4:       send(r_type(F_SLT, rd, rs, rt));
				5:       send(r_type(F_SLTU, rd, rs, rt));
				6:       send(i_type(OP_ADDI, rt, rs, r[31:16]));
				7:       send(i_type(OP_SLTI, rt, rs, r[31:16]));
				8:       send(i_type(OP_ORI, rt, rs, r[31:16]));
				9:       send(i_type(OP_LW, rt, 5'd0, moff));
				default: send(i_type(OP_SW, rt, 5'd0, moff));
			endcase
		end
		drain();
		report_test("random", e0);
	endtask

	initial begin
		seed        = 57463;
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		for (int i = 0; i < `CORE_DMEM_WORDS; i++)
			model_mem[i] = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		test_reset_state();
		test_forward_chain();
		test_immediates();
		test_load_use();
		test_r0_writes();
		test_random();

		$display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- src/pipe_core.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module pipe_core
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    instr_valid,
	input  logic [31:0]             instr,
	output logic                    instr_ready,
	output logic                    wb_valid,
	output logic [`CORE_REG_AW-1:0] wb_reg,
	output logic [`CORE_DATA_W-1:0] wb_data
);

	instr_fields_t           id_instr;
	ctrl_t                   id_ctrl;
	logic [`CORE_DATA_W-1:0] id_imm;
	logic [`CORE_DATA_W-1:0] id_a;
	logic [`CORE_DATA_W-1:0] id_b;
	logic                    stall;
	logic [1:0]              fwd_a;
	logic [1:0]              fwd_b;
	logic [`CORE_DATA_W-1:0] ex_a;
	logic [`CORE_DATA_W-1:0] ex_b_reg;
	logic [`CORE_DATA_W-1:0] ex_b;
	logic [`CORE_DATA_W-1:0] ex_result;
	logic [`CORE_DATA_W-1:0] mem_rd;
	idex_t                   idex;
	exmem_t                  exmem;
	memwb_t                  memwb;

	function automatic logic [`CORE_DATA_W-1:0] fwd_mux(input logic [1:0] sel,
		input logic [`CORE_DATA_W-1:0] reg_val, mem_val, wb_val);
		case (sel)
			2'b01:   return mem_val;
			2'b10:   return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign instr_ready = ~stall;

	// --------------------
	// Decode
	// --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			id_instr <= '0;
		else if (instr_ready)
			id_instr <= instr_valid ? instr_fields_t'(instr) : '0; // Zero word decodes to NOP
	end

	decoder u_decoder (.instr(id_instr), .ctrl(id_ctrl), .imm_ext(id_imm));

	reg_file u_reg_file (
		.clk(clk), .reset(reset),
		.we(memwb.reg_write), .wa(memwb.dest), .wd(memwb.result),
		.ra1(id_instr.rs), .ra2(id_instr.rt),
		.rd1(id_a), .rd2(id_b)
	);

	hazard_unit u_hazard_unit (
		.id_rs(id_instr.rs), .id_rt(id_instr.rt),
		.id_uses_rs(id_ctrl.uses_rs), .id_uses_rt(id_ctrl.uses_rt),
		.ex_ctrl(idex.ctrl), .ex_rs(idex.rs), .ex_rt(idex.rt),
		.mem_ctrl(exmem.ctrl), .wb_write(memwb.reg_write), .wb_dest(memwb.dest),
		.stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			idex <= '0;
		else if (stall)
			idex <= '0; // Bubble behind the load
		else
			idex <= '{ctrl: id_ctrl, rs: id_instr.rs, rt: id_instr.rt,
			          a: id_a, b: id_b, imm: id_imm};
	end

	// --------------------
	// Execute
	// --------------------
	assign ex_a     = fwd_mux(fwd_a, idex.a, exmem.alu_result, memwb.result);
	assign ex_b_reg = fwd_mux(fwd_b, idex.b, exmem.alu_result, memwb.result);
	assign ex_b     = idex.ctrl.alu_src_imm ? idex.imm : ex_b_reg;

	alu u_alu (.op(idex.ctrl.alu_op), .a(ex_a), .b(ex_b), .result(ex_result));

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			exmem <= '0;
		else
			exmem <= '{ctrl: idex.ctrl, alu_result: ex_result, store_data: ex_b_reg};
	end

	// Memory stage
	data_mem u_data_mem (
		.clk(clk), .reset(reset), .we(exmem.ctrl.mem_write),
		.addr(exmem.alu_result[`CORE_DMEM_AW+1:2]), .wd(exmem.store_data), .rd(mem_rd)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			memwb <= '0;
		else
			memwb <= '{reg_write: exmem.ctrl.reg_write, dest: exmem.ctrl.dest,
			           result: exmem.ctrl.mem_to_reg ? mem_rd : exmem.alu_result};
	end

	// Writeback report
	assign wb_valid = memwb.reg_write;
	assign wb_reg   = memwb.dest;
	assign wb_data  = memwb.result;

	a_wb_nonzero: assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_reg != '0);
	a_stall_once: assert property (@(posedge clk) disable iff (reset) stall |=> !stall);

endmodule

//--- src/data_mem.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module data_mem (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     we,
	input  logic [`CORE_DMEM_AW-1:0] addr,
	input  logic [`CORE_DATA_W-1:0]  wd,
	output logic [`CORE_DATA_W-1:0]  rd
);

	logic [`CORE_DATA_W-1:0] mem [0:`CORE_DMEM_WORDS-1];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `CORE_DMEM_WORDS; i++)
				mem[i] <= '0;
		end else if (we) begin
			mem[addr] <= wd;
		end
	end

	assign rd = mem[addr]; // Combinational read

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module hazard_unit
	import pipe_pkg::*;
(
	input  logic [`CORE_REG_AW-1:0] id_rs,
	input  logic [`CORE_REG_AW-1:0] id_rt,
	input  logic                    id_uses_rs,
	input  logic                    id_uses_rt,
	input  ctrl_t                   ex_ctrl,
	input  logic [`CORE_REG_AW-1:0] ex_rs,
	input  logic [`CORE_REG_AW-1:0] ex_rt,
	input  ctrl_t                   mem_ctrl,
	input  logic                    wb_write,
	input  logic [`CORE_REG_AW-1:0] wb_dest,
	output logic                    stall,
	output logic [1:0]              fwd_a,
	output logic [1:0]              fwd_b
);

	// Select codes: 00 register, 01 memory stage, 10 writeback
	function automatic logic [1:0] pick_fwd(input logic uses,
	                                        input logic [`CORE_REG_AW-1:0] src);
		logic [1:0] sel;
		if (!uses)
			sel = 2'b00;
		else if (mem_ctrl.reg_write && mem_ctrl.dest == src)
			sel = 2'b01; // Youngest value wins
		else if (wb_write && wb_dest == src)
			sel = 2'b10;
		else
			sel = 2'b00;
		return sel;
	endfunction

	// --------------------
	// Load-use detection
	// --------------------
	// A load in memory never feeds execute, the bubble below prevents it
	always_comb begin
		stall = ex_ctrl.is_load && ex_ctrl.reg_write &&
		        ((id_uses_rs && ex_ctrl.dest == id_rs) ||
		         (id_uses_rt && ex_ctrl.dest == id_rt));
	end

	always_comb begin
		fwd_a = pick_fwd(ex_ctrl.uses_rs, ex_rs);
		fwd_b = pick_fwd(ex_ctrl.uses_rt, ex_rt);
	end

endmodule

//--- src/alu.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module alu
	import pipe_pkg::*;
(
	input  alu_op_e                 op,
	input  logic [`CORE_DATA_W-1:0] a,
	input  logic [`CORE_DATA_W-1:0] b,
	output logic [`CORE_DATA_W-1:0] result
);

	localparam int W = `CORE_DATA_W;

	logic [W:0]   sub_full;
	logic [W-1:0] diff;
	logic         borrow;
	logic         overflow;
	logic         lt_signed;

	assign sub_full  = {1'b0, a} + {1'b0, ~b} + {{W{1'b0}}, 1'b1};
	assign diff      = sub_full[W-1:0];
	assign borrow    = ~sub_full[W];                            // No carry out means a < b
	assign overflow  = (a[W-1] ^ b[W-1]) & (diff[W-1] ^ a[W-1]);
	assign lt_signed = diff[W-1] ^ overflow;

	always_comb begin
		case (op)
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = diff;
			ALU_SLT:  result = {{(W-1){1'b0}}, lt_signed};
			ALU_SLTU: result = {{(W-1){1'b0}}, borrow};
			default:  result = '0;
		endcase
	end

endmodule

//--- src/reg_file.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    we,
	input  logic [`CORE_REG_AW-1:0] wa,
	input  logic [`CORE_DATA_W-1:0] wd,
	input  logic [`CORE_REG_AW-1:0] ra1,
	input  logic [`CORE_REG_AW-1:0] ra2,
	output logic [`CORE_DATA_W-1:0] rd1,
	output logic [`CORE_DATA_W-1:0] rd2
);

	logic [`CORE_DATA_W-1:0] regs [1:(1<<`CORE_REG_AW)-1];

	// Zero register, then same-cycle write bypass, then array
	function automatic logic [`CORE_DATA_W-1:0] read_port(input logic [`CORE_REG_AW-1:0] ra);
		if (ra == '0)
			return '0;
		else if (we && wa == ra)
			return wd;
		else
			return regs[ra];
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 1; i < (1 << `CORE_REG_AW); i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	always_comb begin
		rd1 = read_port(ra1);
		rd2 = read_port(ra2);
	end

	// Decoder clears reg_write for r0 destinations
	a_no_r0_write: assert property (@(posedge clk) disable iff (reset) !(we && wa == '0));

endmodule

//--- src/decoder.sv
`timescale 1ns/10ps
`include "core_defines.svh"

module decoder
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  instr_fields_t           instr,
	output ctrl_t                   ctrl,
	output logic [`CORE_DATA_W-1:0] imm_ext
);

	logic zero_ext;

	always_comb begin
		ctrl     = CTRL_NOP;
		zero_ext = 1'b0;
		case (instr.opcode)
			OP_RTYPE: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest      = instr.tail.r.rd;
				ctrl.uses_rs   = 1'b1;
				ctrl.uses_rt   = 1'b1;
				case (instr.tail.r.funct)
					F_ADD:   ctrl.alu_op = ALU_ADD;
					F_SUB:   ctrl.alu_op = ALU_SUB;
					F_AND:   ctrl.alu_op = ALU_AND;
					F_OR:    ctrl.alu_op = ALU_OR;
					F_SLT:   ctrl.alu_op = ALU_SLT;
					F_SLTU:  ctrl.alu_op = ALU_SLTU;
					default: ctrl = CTRL_NOP; // Also covers the all-zero bubble
				endcase
			end
			OP_ADDI, OP_SLTI, OP_ORI: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write   = 1'b1;
				ctrl.dest        = instr.rt;
				ctrl.uses_rs     = 1'b1;
				if (instr.opcode == OP_ADDI)
					ctrl.alu_op = ALU_ADD;
				else if (instr.opcode == OP_SLTI)
					ctrl.alu_op = ALU_SLT;
				else begin
					ctrl.alu_op = ALU_OR;
					zero_ext    = 1'b1; // Logical immediate
				end
			end
			OP_LW: begin
				ctrl.alu_op      = ALU_ADD;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				ctrl.reg_write   = 1'b1;
				ctrl.dest        = instr.rt;
				ctrl.uses_rs     = 1'b1;
				ctrl.is_load     = 1'b1;
			end
			OP_SW: begin
				ctrl.alu_op      = ALU_ADD;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
				ctrl.uses_rs     = 1'b1;
				ctrl.uses_rt     = 1'b1; // Store data
			end
			default: ctrl = CTRL_NOP;
		endcase

		// r0 is never written
		if (ctrl.dest == '0)
			ctrl.reg_write = 1'b0;
	end

	assign imm_ext = zero_ext ?
		{{(`CORE_DATA_W-16){1'b0}}, instr.tail.imm} :
		{{(`CORE_DATA_W-16){instr.tail.imm[15]}}, instr.tail.imm};

endmodule

//--- src/pipe_pkg.sv
`include "core_defines.svh"

package pipe_pkg;

	typedef enum logic [2:0] {
		ALU_AND  = 3'd0,
		ALU_OR   = 3'd1,
		ALU_ADD  = 3'd2,
		ALU_SUB  = 3'd3,
		ALU_SLT  = 3'd4,
		ALU_SLTU = 3'd5
	} alu_op_e;

	typedef struct packed {
		alu_op_e                 alu_op;
		logic                    alu_src_imm; // Operand B from immediate
		logic                    mem_write;
		logic                    mem_to_reg;  // Load data to writeback
		logic                    reg_write;
		logic [`CORE_REG_AW-1:0] dest;
		logic                    uses_rs;
		logic                    uses_rt;
		logic                    is_load;
	} ctrl_t;

	// All flags clear, nothing written
	localparam ctrl_t CTRL_NOP = '0;

	// --------------------
	// Stage registers
	// --------------------
	typedef struct packed {
		ctrl_t                   ctrl;
		logic [`CORE_REG_AW-1:0] rs;
		logic [`CORE_REG_AW-1:0] rt;
		logic [`CORE_DATA_W-1:0] a;
		logic [`CORE_DATA_W-1:0] b;
		logic [`CORE_DATA_W-1:0] imm;
	} idex_t;

	typedef struct packed {
		ctrl_t                   ctrl;
		logic [`CORE_DATA_W-1:0] alu_result;
		logic [`CORE_DATA_W-1:0] store_data;
	} exmem_t;

	typedef struct packed {
		logic                    reg_write;
		logic [`CORE_REG_AW-1:0] dest;
		logic [`CORE_DATA_W-1:0] result;
	} memwb_t;

endpackage

//--- src/isa_pkg.sv
`include "core_defines.svh"

package isa_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_SLTI  = 6'h0a,
		OP_ORI   = 6'h0d,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		F_ADD  = 6'h20,
		F_SUB  = 6'h22,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_SLT  = 6'h2a,
		F_SLTU = 6'h2b
	} funct_e;

	// Low half is either R-type fields or a 16-bit immediate
	typedef struct packed {
		opcode_e                opcode;
		logic [`CORE_REG_AW-1:0] rs;
		logic [`CORE_REG_AW-1:0] rt;
		union packed {
			struct packed {
				logic [`CORE_REG_AW-1:0] rd;
				logic [4:0]              shamt;
				funct_e                  funct;
			} r;
			logic [15:0] imm;
		} tail;
	} instr_fields_t;

endpackage

//--- src/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// --------------------
// Datapath sizes
// --------------------
`define CORE_DATA_W     32
`define CORE_REG_AW     5

// Data memory
`define CORE_DMEM_WORDS 64
`define CORE_DMEM_AW    6

`endif
